/* verilog/vertex_pkg.sv */
package vertex_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int vertex_bits           = 32; // one vertex value, also the id
	localparam int addr_bits             = 32;
	localparam int cacheline_vertex_num  = 4;
	localparam int cacheline_bits        = 128;
	localparam int cacheline_bytes       = 16; // address step per batch
	localparam int array_num             = 6;
	localparam int job_fifo_depth        = 16;
	localparam int job_fifo_alfull_level = 14; // leaves room for the record in flight
	localparam int count_bits            = 3;  // batch count 0..4

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	// per-vertex arrays, in request order
	typedef enum logic [2:0] {
		in_degree,
		out_degree,
		edges_idx,
		inv_in_degree,
		inv_out_degree,
		inv_edges_idx
	} vertex_struct_t;

	// work descriptor
	typedef struct packed {
		logic                                   valid;
		logic [vertex_bits-1:0]                 num_vertices;
		logic [array_num-1:0][addr_bits-1:0]    base; // indexed by vertex_struct_t
	} wed_t;

	typedef struct packed {
		logic                  valid;
		logic [addr_bits-1:0]  address;
		logic [count_bits-1:0] real_size; // vertices in this line
		vertex_struct_t        tag;
	} read_command_t;

	typedef struct packed {
		logic                      valid;
		vertex_struct_t            tag;
		logic [count_bits-1:0]     real_size;
		logic [cacheline_bits-1:0] data; // lowest vertex in the low word
	} read_response_t;

	// one assembled vertex
	typedef struct packed {
		logic                                  valid;
		logic [vertex_bits-1:0]                id;
		logic [array_num-1:0][vertex_bits-1:0] values; // indexed by vertex_struct_t
	} vertex_job_t;

	typedef struct packed {
		logic empty;
		logic alfull;
		logic full;
	} buffer_status_t;

endpackage

/* verilog/vertex_read_requester.sv */
`timescale 1ns/1ps

module vertex_read_requester (
	input  logic                      clock,
	input  logic                      rstn,
	input  vertex_pkg::wed_t          wed,
	input  logic                      read_alfull,
	input  logic                      response_strobe,
	input  logic                      batch_ready,
	output vertex_pkg::read_command_t read_command
);

	import vertex_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_issue
	} req_state_t;

	req_state_t state;

	wed_t                   wed_q;       // captured descriptor
	logic [vertex_bits-1:0] remaining;   // vertices not yet requested
	logic [addr_bits-1:0]   offset;      // byte offset of current batch
	logic [count_bits-1:0]  batch_size;
	vertex_struct_t         cur_array;   // next array to request
	logic [3:0]             outstanding; // commands without a response

	logic                  batch_start;
	logic                  issue_fire;
	logic [count_bits-1:0] next_size;

	//////////////////////////////////////////////////
	// batch sizing
	//////////////////////////////////////////////////

	assign next_size = (remaining >= cacheline_vertex_num) ?
		count_bits'(cacheline_vertex_num) : remaining[count_bits-1:0];

	assign batch_start = (state == st_wait) && (remaining != '0) &&
		(outstanding == '0) && batch_ready;

	assign issue_fire = (state == st_issue) && !read_alfull; // held back on alfull

	//////////////////////////////////////////////////
	// command FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= st_idle;
			remaining <= '0;
			offset    <= '0;
			batch_size <= '0;
			cur_array <= in_degree;
		end else begin
			case (state)
				st_idle: begin
					if (wed.valid) begin
						remaining <= wed.num_vertices;
						offset    <= '0;
						state     <= st_wait;
					end
				end
				st_wait: begin
					if (batch_start) begin
						batch_size <= next_size;
						remaining  <= remaining - vertex_bits'(next_size);
						cur_array  <= in_degree;
						state      <= st_issue;
					end else if (remaining == '0 && outstanding == '0) begin
						state <= st_idle; // job done
					end
				end
				st_issue: begin
					if (issue_fire) begin
						if (cur_array == inv_edges_idx) begin
							offset <= offset + addr_bits'(cacheline_bytes);
							state  <= st_wait;
						end else begin
							cur_array <= vertex_struct_t'(cur_array + 3'd1);
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// base addresses only change on a new job
	always_ff @(posedge clock) begin
		if (state == st_idle && wed.valid)
			wed_q <= wed;
	end

	//////////////////////////////////////////////////
	// outstanding responses
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({issue_fire, response_strobe})
				2'b10:   outstanding <= outstanding + 4'd1;
				2'b01:   outstanding <= outstanding - 4'd1;
				default: outstanding <= outstanding; // both or neither
			endcase
		end
	end

	// command goes out in the issue cycle itself
	always_comb begin
		read_command.valid     = issue_fire;
		read_command.address   = wed_q.base[cur_array] + offset;
		read_command.real_size = batch_size;
		read_command.tag       = cur_array;
	end

endmodule

/* verilog/cacheline_stream.sv */
`timescale 1ns/1ps

module cacheline_stream #(
	parameter vertex_pkg::vertex_struct_t stream_array = vertex_pkg::in_degree
) (
	input  logic                              clock,
	input  logic                              rstn,
	input  vertex_pkg::read_response_t        read_response,
	input  logic                              shift,
	output logic [vertex_pkg::vertex_bits-1:0] value,
	output logic                              loaded
);

	import vertex_pkg::*;

	logic [cacheline_bits-1:0] line;  // remaining values, next one lowest
	logic [count_bits-1:0]     count; // values left in line
	logic                      hit;

	assign hit = read_response.valid && (read_response.tag == stream_array);

	//////////////////////////////////////////////////
	// count
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= '0;
		end else begin
			if (hit)
				count <= read_response.real_size;
			else if (shift && count != '0)
				count <= count - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// line data
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (hit)
			line <= read_response.data;
		else if (shift && count != '0)
			line <= line >> vertex_bits; // step to next vertex
	end

	assign value  = line[vertex_bits-1:0];
	assign loaded = (count != '0);

endmodule

/* verilog/vertex_assembler.sv */
`timescale 1ns/1ps

module vertex_assembler (
	input  logic                                                         clock,
	input  logic                                                         rstn,
	input  logic [vertex_pkg::array_num-1:0][vertex_pkg::vertex_bits-1:0] values,
	input  logic [vertex_pkg::array_num-1:0]                             loaded,
	input  logic                                                         fifo_alfull,
	output logic                                                         shift,
	output logic                                                         batch_ready,
	output logic                                                         push,
	output vertex_pkg::vertex_job_t                                      record,
	output logic [vertex_pkg::vertex_bits-1:0]                           filtered_count
);

	import vertex_pkg::*;

	logic                                  rec_valid;
	logic [vertex_bits-1:0]                rec_id;
	logic [array_num-1:0][vertex_bits-1:0] rec_values;
	logic [vertex_bits-1:0]                id_count; // every assembled vertex
	logic                                  no_neighbors;
	logic                                  filter;

	//////////////////////////////////////////////////
	// shift control
	//////////////////////////////////////////////////

	assign shift       = (&loaded) && !fifo_alfull;
	assign batch_ready = !(|loaded) && !fifo_alfull; // streams drained

	//////////////////////////////////////////////////
	// record build
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rec_valid <= 1'b0;
			id_count  <= '0;
		end else begin
			rec_valid <= shift;
			if (shift)
				id_count <= id_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (shift) begin
			rec_id     <= id_count;
			rec_values <= values;
		end
	end

	assign record.valid  = rec_valid;
	assign record.id     = rec_id;
	assign record.values = rec_values;

	// no inverse out neighbors, nothing to schedule
	assign no_neighbors = (rec_values[inv_out_degree] == '0);
	assign push         = rec_valid && !no_neighbors;
	assign filter       = rec_valid && no_neighbors;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			filtered_count <= '0;
		else if (filter)
			filtered_count <= filtered_count + 1'b1;
	end

endmodule

/* verilog/job_fifo.sv */
`timescale 1ns/1ps

module job_fifo (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       push,
	input  vertex_pkg::vertex_job_t    data_in,
	input  logic                       pop,
	output vertex_pkg::vertex_job_t    data_out,
	output vertex_pkg::buffer_status_t status
);

	import vertex_pkg::*;

	vertex_job_t mem [job_fifo_depth];

	logic [$clog2(job_fifo_depth)-1:0] wr_ptr;
	logic [$clog2(job_fifo_depth)-1:0] rd_ptr;
	logic [$clog2(job_fifo_depth):0]   count;
	logic                              do_push;
	logic                              do_pop;
	logic                              out_valid;
	vertex_job_t                       out_data;

	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			out_valid <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count     <= count + do_push - do_pop;
			out_valid <= do_pop; // one cycle per pop
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			out_data <= mem[rd_ptr];
	end

	always_comb begin
		data_out       = out_data;
		data_out.valid = out_valid;
	end

	assign status.empty  = (count == '0);
	assign status.alfull = (count >= job_fifo_alfull_level);
	assign status.full   = (count == job_fifo_depth);

endmodule

/* verilog/vertex_job_control.sv */
`timescale 1ns/1ps

module vertex_job_control (
	input  logic                               clock,
	input  logic                               rstn,
	input  vertex_pkg::wed_t                   wed,
	input  vertex_pkg::read_response_t         read_response,
	input  logic                               read_alfull,
	input  logic                               job_pop,
	output vertex_pkg::read_command_t          read_command,
	output vertex_pkg::vertex_job_t            vertex_job,
	output vertex_pkg::buffer_status_t         job_status,
	output logic [vertex_pkg::vertex_bits-1:0] filtered_count
);

	import vertex_pkg::*;

	logic [array_num-1:0][vertex_bits-1:0] values;
	logic [array_num-1:0]                  loaded;
	logic                                  shift;
	logic                                  batch_ready;
	logic                                  push;
	vertex_job_t                           record;

	//////////////////////////////////////////////////
	// read requests
	//////////////////////////////////////////////////

	vertex_read_requester vertex_read_requester_i (
		.clock           (clock),
		.rstn            (rstn),
		.wed             (wed),
		.read_alfull     (read_alfull),
		.response_strobe (read_response.valid),
		.batch_ready     (batch_ready),
		.read_command    (read_command)
	);

	//////////////////////////////////////////////////
	// one stream per array
	//////////////////////////////////////////////////

	for (genvar a = 0; a < array_num; a++) begin : g_stream
		cacheline_stream #(
			.stream_array (vertex_struct_t'(a))
		) cacheline_stream_i (
			.clock         (clock),
			.rstn          (rstn),
			.read_response (read_response),
			.shift         (shift),
			.value         (values[a]),
			.loaded        (loaded[a])
		);
	end

	//////////////////////////////////////////////////
	// assembly and job queue
	//////////////////////////////////////////////////

	vertex_assembler vertex_assembler_i (
		.clock          (clock),
		.rstn           (rstn),
		.values         (values),
		.loaded         (loaded),
		.fifo_alfull    (job_status.alfull),
		.shift          (shift),
		.batch_ready    (batch_ready),
		.push           (push),
		.record         (record),
		.filtered_count (filtered_count)
	);

	job_fifo job_fifo_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (push),
		.data_in  (record),
		.pop      (job_pop),
		.data_out (vertex_job),
		.status   (job_status)
	);

endmodule

/* bench/vertex_job_control_sva.sv */
`timescale 1ns/1ps

module vertex_job_control_sva (
	input logic                       clock,
	input logic                       rstn,
	input logic                       read_alfull,
	input logic                       job_pop,
	input vertex_pkg::read_command_t  read_command,
	input vertex_pkg::vertex_job_t    vertex_job,
	input vertex_pkg::buffer_status_t job_status
);

	//////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////

	no_command_on_alfull: assert property (@(posedge clock) disable iff (!rstn)
		read_alfull |-> !read_command.valid)
		else $error("read command issued while read_alfull high");

	//////////////////////////////////////////////////
	// job queue
	//////////////////////////////////////////////////

	job_only_after_pop: assert property (@(posedge clock) disable iff (!rstn)
		vertex_job.valid |-> $past(job_pop))
		else $error("vertex_job.valid without a pop in the previous cycle");

	flags_exclusive: assert property (@(posedge clock) disable iff (!rstn)
		!(job_status.full && job_status.empty))
		else $error("job FIFO full and empty at once");

endmodule

/* bench/vertex_job_control_tb.sv */
`timescale 1ns/1ps

module vertex_job_control_tb;

	import vertex_pkg::*;

	typedef struct {
		string       name;
		int          num;
		logic [31:0] base0; // array a sits at base0 + a * 0x1000
		int          stall; // percent of cycles with read_alfull high
		int          pop;   // percent chance of a pop when not empty
		bit          fill;  // hold pops until the FIFO reports almost full
	} test_row_t;

	logic                   clock = 1'b0;
	logic                   rstn;
	wed_t                   wed;
	read_response_t         read_response;
	logic                   read_alfull;
	logic                   job_pop;
	read_command_t          read_command;
	vertex_job_t            vertex_job;
	buffer_status_t         job_status;
	logic [vertex_bits-1:0] filtered_count;

	test_row_t      rows [5];
	test_row_t      row = '{"reset", 0, 32'h0, 0, 0, 1'b0};
	integer         seed = 32'h64df07bb;
	int             cycle = 0;
	int             cmd_count = 0;
	int             filtered_total = 0;
	int             limit = 1000;
	int             error_count = 0;
	logic           pop_last = 1'b0;
	logic           alfull_seen = 1'b0;
	read_response_t resp_q [$];
	int             due_q [$];
	vertex_job_t    job_q [$]; // expected jobs in pop order
	int             filt_q [$]; // filtered vertices ahead of each expected job

	vertex_job_control vertex_job_control_i (.*);

	bind vertex_job_control vertex_job_control_sva vertex_job_control_sva_i (
		.clock (clock), .rstn (rstn), .read_alfull (read_alfull), .job_pop (job_pop),
		.read_command (read_command), .vertex_job (vertex_job), .job_status (job_status)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] array_value(int a, int v);
		if (a == inv_out_degree && v % 3 == 0)
			return 32'h0; // no inverse out edges
		return (32'(a) << 24) + 32'(v);
	endfunction

	function automatic logic [31:0] base_of(int a);
		return row.base0 + 32'(a) * 32'h1000;
	endfunction

	function automatic int percent();
		return ($random(seed) & 32'h7fff_ffff) % 100;
	endfunction

	task automatic fail_run(string msg);
		error_count++;
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(string what, logic [255:0] expected, logic [255:0] actual);
		assert (expected === actual) else
			fail_run($sformatf("FAIL %s %s: expected %0h actual %0h",
				row.name, what, expected, actual));
	endtask

	//////////////////////////////////////////////////
	// command checks and memory model
	//////////////////////////////////////////////////

	always @(posedge clock) begin : command_monitor
		read_response_t r;
		int a;
		int b;
		int v;
		cycle++;
		if (rstn && read_command.valid) begin
			a = cmd_count % array_num;
			b = cmd_count / array_num; // batch index
			check("command tag", a, read_command.tag);
			check("command address", base_of(a) + b * cacheline_bytes, read_command.address);
			check("command real_size", (row.num - 4 * b < 4) ? row.num - 4 * b : 4,
				read_command.real_size);
			v = (read_command.address - base_of(a)) / cacheline_bytes * cacheline_vertex_num;
			r.valid     = 1'b1;
			r.tag       = read_command.tag;
			r.real_size = read_command.real_size;
			for (int k = 0; k < cacheline_vertex_num; k++)
				r.data[k*vertex_bits +: vertex_bits] = array_value(a, v + k);
			resp_q.push_back(r);
			due_q.push_back(cycle + 1 + percent() % 8);
			cmd_count++;
		end
	end

	// responses leave in order, head only
	always @(negedge clock) begin : drivers
		read_response = '0;
		if (due_q.size() > 0 && due_q[0] <= cycle) begin
			read_response = resp_q.pop_front();
			void'(due_q.pop_front());
		end
		if (job_status.alfull)
			alfull_seen = 1'b1;
		read_alfull = (percent() < row.stall);
		job_pop     = (percent() < row.pop) && !job_status.empty &&
			(!row.fill || alfull_seen);
	end

	//////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////

	always @(posedge clock) begin : job_monitor
		vertex_job_t exp;
		int          min_filtered;
		if (rstn) begin
			check("vertex_job.valid", pop_last, vertex_job.valid);
			assert (!job_status.full) else fail_run("job FIFO reached full");
			assert (!(read_alfull && read_command.valid)) else
				fail_run("read command issued while read_alfull was high");
			assert (filtered_count <= filtered_total) else
				fail_run("filtered_count ran past the number of zero-degree vertices");
			if (vertex_job.valid) begin
				assert (job_q.size() > 0) else fail_run("job popped when none was expected");
				exp          = job_q.pop_front();
				min_filtered = filt_q.pop_front();
				check("job id", exp.id, vertex_job.id);
				check("job values", exp.values, vertex_job.values);
				// every vertex ahead of this one is assembled by now
				assert (filtered_count >= min_filtered) else
					fail_run($sformatf("FAIL %s filtered_count at job %0d: %s %0d actual %0d",
						row.name, exp.id, "expected at least", min_filtered,
						filtered_count));
			end
			pop_last = job_pop;
		end
	end

	initial begin : main
		int          id_base;
		vertex_job_t exp;
		rows[0] = '{"single_vertex", 1, 32'h0001_0000, 0, 100, 1'b0};
		rows[1] = '{"one_line", 4, 32'h0002_0000, 20, 90, 1'b0};
		rows[2] = '{"partial_line", 7, 32'h0003_0000, 30, 70, 1'b0};
		rows[3] = '{"three_lines", 10, 32'h0004_0000, 10, 50, 1'b0};
		rows[4] = '{"backpressure", 23, 32'h0005_0000, 60, 4, 1'b1}; // fills the FIFO
		foreach (rows[i])
			limit += rows[i].num * 200;
		fork
			begin
				repeat (limit) @(posedge clock);
				fail_run($sformatf("timeout after %0d cycles, run did not finish", limit));
			end
		join_none
		rstn          = 1'b0;
		wed           = '0;
		read_response = '0;
		read_alfull   = 1'b0;
		job_pop       = 1'b0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check("read_command.valid", 0, read_command.valid);
		check("vertex_job.valid", 0, vertex_job.valid);
		check("job_status", 3'b100, job_status); // empty only
		check("filtered_count", 0, filtered_count);
		id_base = 0;
		foreach (rows[i]) begin
			row         = rows[i];
			cmd_count   = 0;
			alfull_seen = 1'b0;
			for (int v = 0; v < row.num; v++) begin
				if (v % 3 == 0) begin
					filtered_total++;
				end else begin
					exp.valid = 1'b1;
					exp.id    = id_base + v; // ids run across rows
					for (int a = 0; a < array_num; a++)
						exp.values[a] = array_value(a, v);
					job_q.push_back(exp);
					filt_q.push_back(filtered_total);
				end
			end
			id_base += row.num;
			wed.valid        = 1'b1;
			wed.num_vertices = row.num;
			for (int a = 0; a < array_num; a++)
				wed.base[a] = base_of(a);
			@(negedge clock);
			wed.valid = 1'b0;
			while (job_q.size() != 0 || filtered_count != filtered_total)
				@(negedge clock);
			repeat (4) @(negedge clock);
			check("command count", array_num * ((row.num + 3) / 4), cmd_count);
			check("filtered_count", filtered_total, filtered_count);
			if (row.fill)
				check("job_status.alfull reached", 1, alfull_seen);
		end
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* vertex_job.f */
verilog/vertex_pkg.sv
verilog/vertex_read_requester.sv
verilog/cacheline_stream.sv
verilog/vertex_assembler.sv
verilog/job_fifo.sv
verilog/vertex_job_control.sv
bench/vertex_job_control_sva.sv
bench/vertex_job_control_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vertex_job_control_tb
FILELIST  ?= vertex_job.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "make test    build with Verilator, run, and search $(LOG) for the pass message"
	@echo "make clean   remove $(BUILD_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
